// File: rtl/wb_intercon_defs.svh
`ifndef WB_INTERCON_DEFS_SVH
`define WB_INTERCON_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WB_AW 32
`define WB_DW 32
`define WB_SELW 4

// ram depth in words, 4 KiB total
`define RAM_ADDR_BITS 10

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RAM_BASE 32'h0000_0000
`define RAM_MASK 32'hFFFF_F000
`define REG_BASE 32'h1000_0000
`define REG_MASK 32'hFFFF_FFF0

// returned by the id register
`define REG_ID_VALUE 32'h5742_0001

`endif

// File: rtl/wb_intercon_pkg.sv
`include "wb_intercon_defs.svh"

package wb_intercon_pkg;

   typedef logic [`WB_AW-1:0]   wb_addr_t;
   typedef logic [`WB_DW-1:0]   wb_data_t;
   typedef logic [`WB_SELW-1:0] wb_sel_t;

   // master to slave
   typedef struct packed {
      wb_addr_t   adr;
      wb_data_t   dat;
      wb_sel_t    sel;
      logic       we;
      logic       cyc;
      logic       stb;
      logic [2:0] cti;
      logic [1:0] bte;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      wb_data_t dat;
      logic     ack;
      logic     err;
      logic     rty;
   } wb_rsp_t;

   typedef enum logic [1:0] {RESP_NONE, RESP_ACK, RESP_ERR, RESP_RTY} wb_resp_kind_e;

   typedef enum logic {REG_IDLE, REG_RESP} reg_state_e;

   // replace the selected byte lanes of a word
   function automatic wb_data_t byte_merge(input wb_data_t old_dat,
                                           input wb_data_t new_dat,
                                           input wb_sel_t  sel);
      wb_data_t res;
      res = old_dat;
      for (int b = 0; b < `WB_SELW; b++) begin
         if (sel[b]) res[8*b +: 8] = new_dat[8*b +: 8];
      end
      return res;
   endfunction

endpackage

// File: rtl/wb_intercon_top.sv
`timescale 1ns/1ps
`include "wb_intercon_defs.svh"

module wb_intercon_top (
   input  logic                       wb_clk_i,
   input  logic                       rst_i,

   // master port
   input  wb_intercon_pkg::wb_req_t   wbm_req_i,
   output wb_intercon_pkg::wb_rsp_t   wbm_rsp_o,

   input  logic                       event_i,
   output wb_intercon_pkg::wb_data_t  scratch0_o
);

   localparam int unsigned NUM_SLAVES = 2;

   // slave 0 is the ram, slave 1 the register block
   wb_intercon_pkg::wb_req_t [NUM_SLAVES-1:0] slv_req;
   wb_intercon_pkg::wb_rsp_t [NUM_SLAVES-1:0] slv_rsp;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   wb_mux #(
      .NUM_SLAVES (NUM_SLAVES),
      .MATCH_ADDR ({`REG_BASE, `RAM_BASE}),
      .MATCH_MASK ({`REG_MASK, `RAM_MASK})
   ) mux_i (
      .wb_clk_i  (wb_clk_i),
      .rst_i     (rst_i),
      .wbm_req_i (wbm_req_i),
      .wbm_rsp_o (wbm_rsp_o),
      .wbs_req_o (slv_req),
      .wbs_rsp_i (slv_rsp)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // slaves
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   wb_ram_slave ram_i (
      .wb_clk_i (wb_clk_i),
      .rst_i    (rst_i),
      .req_i    (slv_req[0]),
      .rsp_o    (slv_rsp[0])
   );

   wb_reg_slave regs_i (
      .wb_clk_i   (wb_clk_i),
      .rst_i      (rst_i),
      .req_i      (slv_req[1]),
      .rsp_o      (slv_rsp[1]),
      .event_i    (event_i),
      .scratch0_o (scratch0_o)
   );

endmodule

// File: rtl/wb_mux.sv
`timescale 1ns/1ps

module wb_mux #(
   parameter int unsigned NUM_SLAVES = 2,
   parameter wb_intercon_pkg::wb_addr_t [NUM_SLAVES-1:0] MATCH_ADDR = '0,
   parameter wb_intercon_pkg::wb_addr_t [NUM_SLAVES-1:0] MATCH_MASK = '0
) (
   input  logic                                       wb_clk_i,
   input  logic                                       rst_i,

   // master port
   input  wb_intercon_pkg::wb_req_t                   wbm_req_i,
   output wb_intercon_pkg::wb_rsp_t                   wbm_rsp_o,

   // slave ports
   output wb_intercon_pkg::wb_req_t [NUM_SLAVES-1:0]  wbs_req_o,
   input  wb_intercon_pkg::wb_rsp_t [NUM_SLAVES-1:0]  wbs_rsp_i
);

   localparam int unsigned SEL_BITS = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

   logic [NUM_SLAVES-1:0]    match;
   logic [SEL_BITS-1:0]      slave_sel;
   logic                     unmapped;
   logic                     err_q;
   wb_intercon_pkg::wb_rsp_t sel_rsp;

   // lowest set bit wins
   function automatic logic [SEL_BITS-1:0] ff1(input logic [NUM_SLAVES-1:0] in);
      logic [SEL_BITS-1:0] idx;
      idx = '0;
      for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
         if (in[i]) idx = SEL_BITS'(i);
      end
      return idx;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // address decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   genvar g;
   generate
      for (g = 0; g < NUM_SLAVES; g++) begin : g_slave
         wb_intercon_pkg::wb_req_t req_s;

         assign match[g] = (wbm_req_i.adr & MATCH_MASK[g]) == MATCH_ADDR[g];

         // everything fans out, only cyc is steered
         always_comb begin
            req_s     = wbm_req_i;
            req_s.cyc = wbm_req_i.cyc & match[g] & (slave_sel == SEL_BITS'(g));
         end

         assign wbs_req_o[g] = req_s;
      end
   endgenerate

   assign slave_sel = ff1(match);
   assign unmapped  = ~(|match);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // unmapped access error
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // single pulse, held request does not retrigger
   always_ff @(posedge wb_clk_i) begin
      if (rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= wbm_req_i.cyc & wbm_req_i.stb & unmapped & ~err_q;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // response select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign sel_rsp = wbs_rsp_i[slave_sel];

   always_comb begin
      wbm_rsp_o     = sel_rsp;
      wbm_rsp_o.err = sel_rsp.err | err_q;
   end

endmodule

// File: rtl/wb_ram_slave.sv
`timescale 1ns/1ps
`include "wb_intercon_defs.svh"

module wb_ram_slave (
   input  logic                      wb_clk_i,
   input  logic                      rst_i,
   input  wb_intercon_pkg::wb_req_t  req_i,
   output wb_intercon_pkg::wb_rsp_t  rsp_o
);

   localparam int unsigned DEPTH = 1 << `RAM_ADDR_BITS;

   wb_intercon_pkg::wb_data_t mem [0:DEPTH-1];

   logic [`RAM_ADDR_BITS-1:0] word_adr;
   logic                      accept;
   logic                      ack_q;
   wb_intercon_pkg::wb_data_t rd_q;

   // word addressed, byte offset dropped
   assign word_adr = req_i.adr[`RAM_ADDR_BITS+1:2];

   // no new access in the ack cycle
   assign accept = req_i.cyc & req_i.stb & ~ack_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // handshake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge wb_clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // storage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // per byte lane write enables
   always_ff @(posedge wb_clk_i) begin
      if (accept & req_i.we) begin
         for (int b = 0; b < `WB_SELW; b++) begin
            if (req_i.sel[b]) begin
               mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
   end

   // registered read port
   always_ff @(posedge wb_clk_i) begin
      if (accept & ~req_i.we) begin
         rd_q <= mem[word_adr];
      end
   end

   assign rsp_o.dat = rd_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;
   assign rsp_o.rty = 1'b0;

endmodule

// File: rtl/wb_reg_slave.sv
`timescale 1ns/1ps
`include "wb_intercon_defs.svh"

module wb_reg_slave (
   input  logic                       wb_clk_i,
   input  logic                       rst_i,
   input  wb_intercon_pkg::wb_req_t   req_i,
   output wb_intercon_pkg::wb_rsp_t   rsp_o,
   input  logic                       event_i,
   output wb_intercon_pkg::wb_data_t  scratch0_o
);

   wb_intercon_pkg::reg_state_e state_q;
   wb_intercon_pkg::wb_data_t   scratch0_q;
   wb_intercon_pkg::wb_data_t   scratch1_q;
   wb_intercon_pkg::wb_data_t   count_q;
   wb_intercon_pkg::wb_data_t   rd_data;
   wb_intercon_pkg::wb_data_t   rsp_dat_q;
   logic                        ack_q;
   logic                        err_q;
   logic                        event_q;
   logic                        access;
   logic                        illegal;
   logic                        wr_ok;
   logic [1:0]                  offset;

   assign offset  = req_i.adr[3:2];
   assign access  = req_i.cyc & req_i.stb & (state_q == wb_intercon_pkg::REG_IDLE);

   // id register is read only
   assign illegal = req_i.we & (offset == 2'd2);
   assign wr_ok   = access & req_i.we & ~illegal;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // response fsm
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge wb_clk_i) begin
      if (rst_i) begin
         state_q <= wb_intercon_pkg::REG_IDLE;
         ack_q   <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         case (state_q)
            wb_intercon_pkg::REG_IDLE: begin
               if (access) begin
                  state_q <= wb_intercon_pkg::REG_RESP;
                  ack_q   <= ~illegal;
                  err_q   <= illegal;
               end
            end
            default: state_q <= wb_intercon_pkg::REG_IDLE;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // registers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge wb_clk_i) begin
      if (rst_i) begin
         scratch0_q <= '0;
         scratch1_q <= '0;
         count_q    <= '0;
         event_q    <= 1'b0;
      end else begin
         event_q <= event_i;
         if (wr_ok && offset == 2'd0)
            scratch0_q <= wb_intercon_pkg::byte_merge(scratch0_q, req_i.dat, req_i.sel);
         if (wr_ok && offset == 2'd1)
            scratch1_q <= wb_intercon_pkg::byte_merge(scratch1_q, req_i.dat, req_i.sel);
         // clear takes priority over a same cycle event
         if (wr_ok && offset == 2'd3) begin
            count_q <= '0;
         end else if (event_i & ~event_q) begin
            count_q <= count_q + 1;
         end
      end
   end

   always_comb begin
      case (offset)
         2'd0:    rd_data = scratch0_q;
         2'd1:    rd_data = scratch1_q;
         2'd2:    rd_data = `REG_ID_VALUE;
         default: rd_data = count_q;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (access) rsp_dat_q <= rd_data;
   end

   assign rsp_o.dat  = rsp_dat_q;
   assign rsp_o.ack  = ack_q;
   assign rsp_o.err  = err_q;
   assign rsp_o.rty  = 1'b0;
   assign scratch0_o = scratch0_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the wb_intercon testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   -f wb_intercon_top.f \
   --top-module wb_intercon_tb \
   -o wb_intercon_sim

out=$(./obj_dir/wb_intercon_sim)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
   exit 0
fi
exit 1

// File: tb/wb_intercon_golden.txt
// columns: op adr dat sel exp_dat exp_resp, all hex
// op 0 read, 1 write, 2 event pulses (dat = count), 3 check scratch0_o, ff end; resp 1 ack, 2 err
// ram write then read
01 00000000 11223344 f 00000000 1
01 00000004 a5a5a5a5 f 00000000 1
01 00000ffc deadbeef f 00000000 1
01 00000800 0badf00d f 00000000 1
00 00000000 00000000 f 11223344 1
00 00000004 00000000 f a5a5a5a5 1
00 00000ffc 00000000 f deadbeef 1
00 00000800 00000000 f 0badf00d 1
// ram partial byte selects
01 00000004 00000000 1 00000000 1
00 00000004 00000000 f a5a5a500 1
01 00000004 12345678 a 00000000 1
00 00000004 00000000 f 12a55600 1
01 00000800 ffffffff 6 00000000 1
00 00000800 00000000 f 0bffff0d 1
// scratch and id registers
01 10000000 cafef00d f 00000000 1
01 10000004 01234567 f 00000000 1
00 10000000 00000000 f cafef00d 1
00 10000004 00000000 f 01234567 1
01 10000000 000000aa 1 00000000 1
00 10000000 00000000 f cafef0aa 1
00 10000008 00000000 f 57420001 1
// id write refused
01 10000008 ffffffff f 00000000 2
00 10000008 00000000 f 57420001 1
// event counter
01 1000000c 00000000 f 00000000 1
00 1000000c 00000000 f 00000000 1
02 00000000 00000005 0 00000000 0
00 1000000c 00000000 f 00000005 1
01 1000000c 12345678 f 00000000 1
02 00000000 00000003 0 00000000 0
00 1000000c 00000000 f 00000003 1
// unmapped addresses, each followed by a valid access
00 20000000 00000000 f 00000000 2
00 00000000 00000000 f 11223344 1
01 20000100 55555555 f 00000000 2
01 10000010 55555555 f 00000000 2
00 10000004 00000000 f 01234567 1
00 00001000 00000000 f 00000000 2
00 00000ffc 00000000 f deadbeef 1
// scratch0 output port
03 00000000 00000000 0 cafef0aa 0
ff 00000000 00000000 0 00000000 0

// File: tb/wb_intercon_tb.sv
`timescale 1ns/1ps

module wb_intercon_tb;

   localparam int MAX_RECORDS    = 64;
   localparam int FIELDS         = 6;
   localparam int TIMEOUT_CYCLES = 20;

   logic                      wb_clk_i;
   logic                      rst_i;
   logic                      event_i;
   wb_intercon_pkg::wb_req_t  wbm_req_i;
   wb_intercon_pkg::wb_rsp_t  wbm_rsp_o;
   wb_intercon_pkg::wb_data_t scratch0_o;

   // op, adr, dat, sel, expected dat, expected response per record
   logic [31:0] gold [0:MAX_RECORDS*FIELDS-1];
   logic [31:0] lfsr_state;
   int          errors;
   int          tests;
   int          failed_tests;

   wb_intercon_top dut_i (
      .wb_clk_i   (wb_clk_i),
      .rst_i      (rst_i),
      .wbm_req_i  (wbm_req_i),
      .wbm_rsp_o  (wbm_rsp_o),
      .event_i    (event_i),
      .scratch0_o (scratch0_o)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #2 wb_clk_i = ~wb_clk_i;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // idle gap source
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 32'h8020_0003;
      return n;
   endfunction

   task take_bit(output logic b);
      b = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
   endtask

   task draw_gap(output int gap);
      logic b0;
      logic b1;
      take_bit(b0);
      take_bit(b1);
      gap = {30'd0, b1, b0};
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic wb_intercon_pkg::wb_resp_kind_e resp_kind(
         input wb_intercon_pkg::wb_rsp_t rsp);
      if (rsp.ack) return wb_intercon_pkg::RESP_ACK;
      if (rsp.err) return wb_intercon_pkg::RESP_ERR;
      if (rsp.rty) return wb_intercon_pkg::RESP_RTY;
      return wb_intercon_pkg::RESP_NONE;
   endfunction

   task check_data(input wb_intercon_pkg::wb_data_t got, input wb_intercon_pkg::wb_data_t exp,
                   input int idx);
      if (got !== exp) begin
         $display("Fail at %0t: test %0d data %h, expected %h", $time, idx, got, exp);
         errors++;
      end
   endtask

   task check_resp(input wb_intercon_pkg::wb_resp_kind_e got,
                   input wb_intercon_pkg::wb_resp_kind_e exp, input int idx);
      if (got !== exp) begin
         $display("Fail at %0t: test %0d response %s, expected %s",
                  $time, idx, got.name(), exp.name());
         errors++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus and event drivers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task bus_idle;
      @(posedge wb_clk_i);
      wbm_req_i <= '0;
   endtask

   task pulse_events(input int count);
      for (int i = 0; i < count; i++) begin
         @(posedge wb_clk_i);
         event_i <= 1'b1;
         @(posedge wb_clk_i);
         event_i <= 1'b0;
      end
   endtask

   // request held until one response bit is seen
   task run_access(input int idx, input logic we, input wb_intercon_pkg::wb_addr_t adr,
                   input wb_intercon_pkg::wb_data_t dat, input wb_intercon_pkg::wb_sel_t sel,
                   input wb_intercon_pkg::wb_data_t exp_dat,
                   input wb_intercon_pkg::wb_resp_kind_e exp_kind);
      wb_intercon_pkg::wb_req_t       req;
      wb_intercon_pkg::wb_resp_kind_e got_kind;
      int                             waited;
      logic                           got;
      req     = '0;
      req.adr = adr;
      req.dat = dat;
      req.sel = sel;
      req.we  = we;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      @(posedge wb_clk_i);
      wbm_req_i <= req;
      waited = 0;
      got    = 1'b0;
      while (!got && waited < TIMEOUT_CYCLES) begin
         @(negedge wb_clk_i);
         waited++;
         got = wbm_rsp_o.ack | wbm_rsp_o.err | wbm_rsp_o.rty;
      end
      if (!got) begin
         $display("bus timed out on transaction %0d at %0t", idx, $time);
         errors++;
      end else begin
         if ($countones({wbm_rsp_o.ack, wbm_rsp_o.err, wbm_rsp_o.rty}) > 1) begin
            $display("more than one response bit raised on transaction %0d at %0t", idx, $time);
            errors++;
         end
         got_kind = resp_kind(wbm_rsp_o);
         check_resp(got_kind, exp_kind, idx);
         if (!we && exp_kind == wb_intercon_pkg::RESP_ACK && got_kind == exp_kind)
            check_data(wbm_rsp_o.dat, exp_dat, idx);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // main sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      logic [7:0] op;
      logic       done;
      int         base;
      int         gap;
      int         errs_before;
      rst_i      = 1'b1;
      event_i    = 1'b0;
      wbm_req_i  = '0;
      errors     = 0;
      tests      = 0;
      failed_tests = 0;
      lfsr_state = 32'd87884;
      done       = 1'b0;
      $readmemh("tb/wb_intercon_golden.txt", gold);
      repeat (3) @(posedge wb_clk_i);
      rst_i <= 1'b0;

      for (int r = 0; r < MAX_RECORDS && !done; r++) begin
         base = r * FIELDS;
         op   = gold[base][7:0];
         if (op == 8'hff) begin
            done = 1'b1;
         end else begin
            errs_before = errors;
            case (op)
               8'h00, 8'h01: begin
                  run_access(r, op[0], gold[base+1], gold[base+2], gold[base+3][3:0],
                             gold[base+4], wb_intercon_pkg::wb_resp_kind_e'(gold[base+5][1:0]));
                  draw_gap(gap);
                  if (gap > 0) begin
                     bus_idle();
                     repeat (gap - 1) @(posedge wb_clk_i);
                  end
               end
               8'h02: begin
                  bus_idle();
                  pulse_events(gold[base+2]);
               end
               8'h03: begin
                  bus_idle();
                  @(negedge wb_clk_i);
                  check_data(scratch0_o, gold[base+4], r);
               end
               default: begin
                  $display("unknown operation %0h in golden record %0d", op, r);
                  errors++;
               end
            endcase
            tests++;
            if (errors != errs_before) failed_tests++;
            $display("test %0d op %0h adr %h: %s", r, op, gold[base+1],
                     (errors == errs_before) ? "ok" : "mismatch");
         end
      end
      if (!done) begin
         $display("golden file has no end record");
         errors++;
      end
      bus_idle();

      $display("%0d tests run, %0d passed, %0d failed", tests, tests - failed_tests, failed_tests);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: wb_intercon_top.f
+incdir+rtl
rtl/wb_intercon_pkg.sv
rtl/wb_mux.sv
rtl/wb_ram_slave.sv
rtl/wb_reg_slave.sv
rtl/wb_intercon_top.sv
tb/wb_intercon_tb.sv
